// File: buffer_fifo.sv
// ====================
// synchronous buffer FIFO with clear and a combinational head read port
// writes while full are dropped, the reader flags them
// ====================
`timescale 1ns/1ps

module buffer_fifo #(
  parameter int BUF_DEPTH = 64
) (
  input  logic                          CLK,
  input  logic                          resetn_all,
  input  logic                          clear,
  input  logic                          wr_en,
  input  logic [pe_buf_pkg::DATA_W-1:0] wr_data,
  input  logic                          rd_en,
  output logic [pe_buf_pkg::DATA_W-1:0] rd_data,
  output logic                          empty,
  output logic                          full
);

  localparam int unsigned AW = $clog2(BUF_DEPTH);

  logic [pe_buf_pkg::DATA_W-1:0] mem [BUF_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          do_wr;
  logic          do_rd;

  assign empty = (count == '0);
  assign full = (count == (AW + 1)'(BUF_DEPTH));
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // head word shown before the pop
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn_all == 1'b0 || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end
    else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop keep the count
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: burst_reader.sv
// ====================
// wishbone classic read sequencer
// serves pending buffer loads lowest index first, one word per bus cycle
// ====================
`timescale 1ns/1ps

module burst_reader #(
  parameter int BURST_LEN = 16
) (
  input  logic                           CLK,
  input  logic                           resetn_all,
  input  pe_buf_pkg::buf_cmd_t           cmd,
  input  pe_buf_pkg::base_addr_t         base_addr,
  output wb_pkg::wb_req_t                wb_o,
  input  wb_pkg::wb_rsp_t                wb_i,
  input  logic [pe_buf_pkg::NUM_BUF-1:0] buf_full,
  output logic [pe_buf_pkg::NUM_BUF-1:0] wr_en,
  output logic [pe_buf_pkg::DATA_W-1:0]  wr_data,
  output pe_buf_pkg::buf_flags_t         flags,
  output logic                           busy
);

  localparam int unsigned NUM_BUF = pe_buf_pkg::NUM_BUF;
  localparam int unsigned IDX_W = $clog2(NUM_BUF);

  // longest load over all buffers, in words
  function automatic int unsigned max_words();
    int unsigned m;
    m = 0;
    for (int b = 0; b < NUM_BUF; b++) begin
      if (pe_buf_pkg::BURSTS_PER_BUF[b] * BURST_LEN > m) begin
        m = pe_buf_pkg::BURSTS_PER_BUF[b] * BURST_LEN;
      end
    end
    return m;
  endfunction

  localparam int unsigned CNT_W = $clog2(max_words());

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQ,
    S_WAIT,
    S_NEXT
  } state_t;

  state_t state;

  logic [NUM_BUF-1:0] pending;
  logic [NUM_BUF-1:0] avail;
  logic [NUM_BUF-1:0] take;
  logic [NUM_BUF-1:0] err_set;
  logic [NUM_BUF-1:0] done_set;
  logic [IDX_W-1:0]   cur;
  logic [IDX_W-1:0]   first;
  logic [CNT_W-1:0]   word_cnt;
  logic [CNT_W-1:0]   last_idx;
  logic               abort;
  logic               kill;
  logic               cyc_q;
  wb_pkg::wb_addr_t   adr_q;
  pe_buf_pkg::buf_flags_t flags_q;

  // single reads only, stb follows cyc
  assign wb_o = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, adr: adr_q};
  assign wr_data = wb_i.dat;
  assign flags = flags_q;
  assign busy = (state != S_IDLE) || (|pending);

  // current load was cleared, now or earlier
  assign kill = abort || cmd.clear[cur];

  // lowest pending buffer not being cleared this cycle
  always_comb begin
    avail = pending & ~cmd.clear;
    first = '0;
    for (int b = NUM_BUF - 1; b >= 0; b--) begin
      if (avail[b]) begin
        first = IDX_W'(b);
      end
    end
  end

  // index of the final word of the current buffer
  always_comb begin
    last_idx = '0;
    for (int b = 0; b < NUM_BUF; b++) begin
      if (cur == IDX_W'(b)) begin
        last_idx = CNT_W'(pe_buf_pkg::BURSTS_PER_BUF[b] * BURST_LEN - 1);
      end
    end
  end

  // per-cycle events: take-up, fifo write, flag sets
  always_comb begin
    take = '0;
    err_set = '0;
    done_set = '0;
    wr_en = '0;
    if (state == S_IDLE && (|avail)) begin
      take[first] = 1'b1;
    end
    if (state == S_WAIT && !kill) begin
      if (wb_i.err) begin
        err_set[cur] = 1'b1;
      end
      else if (wb_i.ack) begin
        // full buffer drops the word
        if (buf_full[cur]) begin
          err_set[cur] = 1'b1;
        end
        else begin
          wr_en[cur] = 1'b1;
        end
      end
    end
    if (state == S_NEXT && !kill) begin
      done_set[cur] = 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn_all == 1'b0) begin
      state <= S_IDLE;
      pending <= '0;
      cur <= '0;
      word_cnt <= '0;
      abort <= 1'b0;
      cyc_q <= 1'b0;
      flags_q <= '0;
    end
    else begin
      pending <= ((pending & ~take) | cmd.load) & ~cmd.clear;
      // load and clear both restart a buffer's flags
      flags_q.done <= (flags_q.done | done_set) & ~(cmd.load | cmd.clear);
      flags_q.error <= (flags_q.error | err_set) & ~(cmd.load | cmd.clear);
      if (state != S_IDLE && cmd.clear[cur]) begin
        abort <= 1'b1;
      end

      case (state)
        S_IDLE: begin
          if (|avail) begin
            cur <= first;
            word_cnt <= '0;
            adr_q <= base_addr[first];
            cyc_q <= 1'b1;
            state <= S_WAIT;
          end
        end
        S_REQ: begin
          if (kill) begin
            state <= S_NEXT;
          end
          else begin
            adr_q <= base_addr[cur] +
                     wb_pkg::wb_addr_t'(word_cnt) * wb_pkg::wb_addr_t'(wb_pkg::BYTES_PER_WORD);
            cyc_q <= 1'b1;
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (wb_i.ack || wb_i.err) begin
            cyc_q <= 1'b0;
            if (wb_i.err) begin
              // rest of this buffer is abandoned, no done
              abort <= 1'b1;
              state <= S_NEXT;
            end
            else if (kill || word_cnt == last_idx) begin
              state <= S_NEXT;
            end
            else begin
              word_cnt <= word_cnt + 1'b1;
              state <= S_REQ;
            end
          end
        end
        S_NEXT: begin
          abort <= 1'b0;
          state <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

endmodule

// File: list.f
wb_pkg.sv
pe_buf_pkg.sv
mem_ctrl_decode.sv
burst_reader.sv
buffer_fifo.sv
pe_status.sv
pe_buf_top.sv
tb_clk_gen.sv
tb_pe_buf.sv

// File: mem_ctrl_decode.sv
// ====================
// memory-control word decoder
// registers the request and clear bits and emits one-cycle pulses on rising bits
// ====================
`timescale 1ns/1ps

module mem_ctrl_decode (
  input  logic                          CLK,
  input  logic                          resetn_all,
  input  logic [pe_buf_pkg::DATA_W-1:0] mem_ctrl,
  output pe_buf_pkg::buf_cmd_t          cmd
);

  localparam int unsigned NUM_BUF = pe_buf_pkg::NUM_BUF;

  // sampled control bits and their previous values
  logic [NUM_BUF-1:0] req_q;
  logic [NUM_BUF-1:0] clr_q;
  logic [NUM_BUF-1:0] req_prev;
  logic [NUM_BUF-1:0] clr_prev;
  pe_buf_pkg::buf_cmd_t cmd_q;

  always_ff @(posedge CLK) begin
    if (resetn_all == 1'b0) begin
      req_q <= '0;
      clr_q <= '0;
      req_prev <= '0;
      clr_prev <= '0;
      cmd_q <= '0;
    end
    else begin
      req_q <= mem_ctrl[pe_buf_pkg::REQ_LSB +: NUM_BUF];
      clr_q <= mem_ctrl[pe_buf_pkg::CLR_LSB +: NUM_BUF];
      req_prev <= req_q;
      clr_prev <= clr_q;
      // a bit left high by software fires only once
      cmd_q.load <= req_q & ~req_prev;
      cmd_q.clear <= clr_q & ~clr_prev;
    end
  end

  assign cmd = cmd_q;

endmodule

// File: pe_buf_pkg.sv
// ====================
// buffer-side constants and types for the PE buffer loader
// indices, burst counts, command and flag structs, register bit positions
// ====================
package pe_buf_pkg;

  localparam int unsigned DATA_W = 32;
  localparam int unsigned NUM_BUF = 3;

  // buffer indices
  localparam int unsigned BUF_WEIGHT = 0;
  localparam int unsigned BUF_INPUT = 1;
  localparam int unsigned BUF_PSUM = 2;

  // bursts fetched per buffer on each load request
  localparam int unsigned BURSTS_PER_BUF [NUM_BUF] = '{
    BUF_WEIGHT: 1,
    BUF_INPUT:  2,
    BUF_PSUM:   3
  };

  // one-cycle pulses per buffer
  typedef struct packed {
    logic [NUM_BUF-1:0] load;
    logic [NUM_BUF-1:0] clear;
  } buf_cmd_t;

  // sticky per-buffer result flags
  typedef struct packed {
    logic [NUM_BUF-1:0] done;
    logic [NUM_BUF-1:0] error;
  } buf_flags_t;

  // per-buffer base byte addresses
  typedef wb_pkg::wb_addr_t [NUM_BUF-1:0] base_addr_t;

  // memory-control word fields
  localparam int unsigned REQ_LSB = 0;
  localparam int unsigned CLR_LSB = 4;

  // status word fields
  localparam int unsigned DONE_LSB = 0;
  localparam int unsigned BUSY_BIT = 8;
  localparam int unsigned ERR_LSB = 16;

endpackage

// File: pe_buf_top.sv
// ====================
// PE buffer loader top level
// control decode, wishbone read sequencer, buffer FIFOs and status word
// ====================
`timescale 1ns/1ps

module pe_buf_top #(
  parameter int BURST_LEN = 16,
  parameter int BUF_DEPTH = 64
) (
  input  logic                                                    CLK,
  input  logic                                                    resetn_all,
  input  logic [pe_buf_pkg::DATA_W-1:0]                           mem_ctrl,
  input  pe_buf_pkg::base_addr_t                                  base_addr,
  output wb_pkg::wb_req_t                                         wb_o,
  input  wb_pkg::wb_rsp_t                                         wb_i,
  input  logic [pe_buf_pkg::NUM_BUF-1:0]                          rd_en,
  output logic [pe_buf_pkg::NUM_BUF-1:0][pe_buf_pkg::DATA_W-1:0]  rd_data,
  output logic [pe_buf_pkg::NUM_BUF-1:0]                          empty,
  output logic [pe_buf_pkg::DATA_W-1:0]                           pe_status
);

  pe_buf_pkg::buf_cmd_t           cmd;
  pe_buf_pkg::buf_flags_t         flags;
  logic [pe_buf_pkg::NUM_BUF-1:0] buf_full;
  logic [pe_buf_pkg::NUM_BUF-1:0] wr_en;
  logic [pe_buf_pkg::DATA_W-1:0]  wr_data;
  logic                           busy;

  mem_ctrl_decode u_decode (
    .CLK        (CLK),
    .resetn_all (resetn_all),
    .mem_ctrl   (mem_ctrl),
    .cmd        (cmd)
  );

  burst_reader #(
    .BURST_LEN (BURST_LEN)
  ) u_reader (
    .CLK        (CLK),
    .resetn_all (resetn_all),
    .cmd        (cmd),
    .base_addr  (base_addr),
    .wb_o       (wb_o),
    .wb_i       (wb_i),
    .buf_full   (buf_full),
    .wr_en      (wr_en),
    .wr_data    (wr_data),
    .flags      (flags),
    .busy       (busy)
  );

  // weights, input activations, partial sums
  for (genvar b = 0; b < pe_buf_pkg::NUM_BUF; b++) begin : u_buf
    buffer_fifo #(
      .BUF_DEPTH (BUF_DEPTH)
    ) u_fifo (
      .CLK        (CLK),
      .resetn_all (resetn_all),
      .clear      (cmd.clear[b]),
      .wr_en      (wr_en[b]),
      .wr_data    (wr_data),
      .rd_en      (rd_en[b]),
      .rd_data    (rd_data[b]),
      .empty      (empty[b]),
      .full       (buf_full[b])
    );
  end

  pe_status u_status (
    .CLK        (CLK),
    .resetn_all (resetn_all),
    .flags      (flags),
    .busy       (busy),
    .pe_status  (pe_status)
  );

endmodule

// File: pe_status.sv
// ====================
// registered status word
// done bits low, busy in the middle, error bits in the upper half
// ====================
`timescale 1ns/1ps

module pe_status (
  input  logic                          CLK,
  input  logic                          resetn_all,
  input  pe_buf_pkg::buf_flags_t        flags,
  input  logic                          busy,
  output logic [pe_buf_pkg::DATA_W-1:0] pe_status
);

  localparam int unsigned NUM_BUF = pe_buf_pkg::NUM_BUF;

  logic [pe_buf_pkg::DATA_W-1:0] status_d;

  // unused bits read as zero
  always_comb begin
    status_d = '0;
    status_d[pe_buf_pkg::DONE_LSB +: NUM_BUF] = flags.done;
    status_d[pe_buf_pkg::BUSY_BIT] = busy;
    status_d[pe_buf_pkg::ERR_LSB +: NUM_BUF] = flags.error;
  end

  always_ff @(posedge CLK) begin
    if (resetn_all == 1'b0) begin
      pe_status <= '0;
    end
    else begin
      pe_status <= status_d;
    end
  end

endmodule

// File: tb_clk_gen.sv
// ====================
// testbench clock and reset source
// 40 ns clock, reset held low for the first four cycles
// ====================
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 20,
  parameter int RESET_CYCLES = 4
) (
  output logic CLK,
  output logic resetn_all
);

  initial begin
    CLK = 1'b0;
    forever #(HALF_PERIOD_NS) CLK = ~CLK;
  end

  // released just after an edge, like the other inputs
  initial begin
    resetn_all = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    resetn_all = 1'b1;
  end

endmodule

// File: tb_pe_buf.sv
// ====================
// testbench for the PE buffer loader
// wishbone memory model with random wait states, table of tests, watchdog
// ====================
`timescale 1ns/1ps

module tb_pe_buf;

  localparam int NUM_BUF = pe_buf_pkg::NUM_BUF;
  localparam int DATA_W = pe_buf_pkg::DATA_W;
  localparam int NUM_ROWS = 6;
  localparam int ROW_CYCLES = 2000;
  localparam realtime TIMEOUT_NS = (NUM_ROWS * ROW_CYCLES + 20) * 40.0;
  localparam int DRIVE_DLY = 1;
  localparam logic [DATA_W-1:0] PATTERN = 32'hA5C3_0F96;
  // words per load from bursts of 16
  localparam int LOAD_WORDS [NUM_BUF] = '{16, 32, 48};

  typedef struct packed {
    logic [8*8-1:0]             name;
    logic [DATA_W-1:0]          ctrl;
    logic [1:0]                 reps;
    logic                       err_en;
    logic [DATA_W-1:0]          err_addr;
    logic [NUM_BUF-1:0][7:0]    pops;
    logic [NUM_BUF-1:0]         empty_exp;
    logic [DATA_W-1:0]          status;
  } row_t;

  logic                              CLK;
  logic                              resetn_all;
  logic [DATA_W-1:0]                 mem_ctrl;
  pe_buf_pkg::base_addr_t            base_addr;
  wb_pkg::wb_req_t                   wb_o;
  wb_pkg::wb_rsp_t                   wb_i;
  logic [NUM_BUF-1:0]                rd_en;
  logic [NUM_BUF-1:0][DATA_W-1:0]    rd_data;
  logic [NUM_BUF-1:0]                empty;
  logic [DATA_W-1:0]                 pe_status;

  row_t              rows [NUM_ROWS];
  logic [15:0]       lfsr_state;
  logic              err_en;
  logic [DATA_W-1:0] err_addr;
  int                n_checks;
  int                n_errors;

  tb_clk_gen u_clk (
    .CLK        (CLK),
    .resetn_all (resetn_all)
  );

  pe_buf_top #(
    .BURST_LEN (16),
    .BUF_DEPTH (64)
  ) u_dut (
    .CLK        (CLK),
    .resetn_all (resetn_all),
    .mem_ctrl   (mem_ctrl),
    .base_addr  (base_addr),
    .wb_o       (wb_o),
    .wb_i       (wb_i),
    .rd_en      (rd_en),
    .rd_data    (rd_data),
    .empty      (empty),
    .pe_status  (pe_status)
  );

  // galois lfsr with taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // 0 to 3 wait states with one lfsr step per bit
  task automatic draw_wait(output int n);
    n = 0;
    for (int i = 0; i < 2; i++) begin
      n = (n << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // done bits at 0 and error bits at 16
  function automatic logic [DATA_W-1:0] status_word(input logic [2:0] done,
                                                    input logic [2:0] err);
    return (DATA_W'(err) << 16) | DATA_W'(done);
  endfunction

  task automatic next_edge();
    @(posedge CLK);
    #DRIVE_DLY;
  endtask

  // memory model returning the address xor a fixed pattern
  always begin : wb_slave
    int wait_cycles;
    @(posedge CLK);
    #DRIVE_DLY;
    if (wb_o.cyc === 1'b1 && wb_o.stb === 1'b1) begin
      n_checks++;
      if (wb_o.we !== 1'b0) begin
        $display("wishbone cycle at address %h was issued as a write", wb_o.adr);
        n_errors++;
      end
      draw_wait(wait_cycles);
      repeat (wait_cycles) next_edge();
      if (err_en && wb_o.adr == err_addr) begin
        wb_i = '{ack: 1'b0, err: 1'b1, dat: '0};
      end
      else begin
        wb_i = '{ack: 1'b1, err: 1'b0, dat: wb_o.adr ^ PATTERN};
      end
      next_edge();
      wb_i = '0;
    end
  end

  // pops are listed psum, input, weight
  task automatic load_table();
    rows[0] = '{"reset", 32'h0, 2'd1, 1'b0, 32'h0, {8'd0, 8'd0, 8'd0}, 3'b111,
                status_word(3'b000, 3'b000)};
    rows[1] = '{"weight", 32'h1, 2'd1, 1'b0, 32'h0, {8'd0, 8'd0, 8'd16}, 3'b111,
                status_word(3'b001, 3'b000)};
    rows[2] = '{"combined", 32'h7, 2'd1, 1'b0, 32'h0, {8'd48, 8'd32, 8'd16}, 3'b111,
                status_word(3'b111, 3'b000)};
    // err on word 20 of the input load
    rows[3] = '{"bus_err", 32'h2, 2'd1, 1'b1, 32'h0000_2050, {8'd0, 8'd20, 8'd0}, 3'b111,
                status_word(3'b101, 3'b010)};
    // 96 words into 64 entries and half of them left for the clear
    rows[4] = '{"overflow", 32'h4, 2'd2, 1'b0, 32'h0, {8'd32, 8'd0, 8'd0}, 3'b011,
                status_word(3'b101, 3'b110)};
    rows[5] = '{"clear", 32'h60, 2'd1, 1'b0, 32'h0, {8'd0, 8'd0, 8'd0}, 3'b111,
                status_word(3'b001, 3'b000)};
  endtask

  // decode and take-up latency, then poll the busy bit
  task automatic wait_idle();
    repeat (4) next_edge();
    while (pe_status[pe_buf_pkg::BUSY_BIT] !== 1'b0) begin
      next_edge();
    end
  endtask

  task automatic run_row(input row_t r);
    logic [DATA_W-1:0] exp_data;
    err_en = r.err_en;
    err_addr = r.err_addr;
    for (int rep = 0; rep < r.reps; rep++) begin
      mem_ctrl = r.ctrl;
      wait_idle();
      mem_ctrl = '0;
      repeat (2) next_edge();
    end
    for (int b = 0; b < NUM_BUF; b++) begin
      for (int i = 0; i < r.pops[b]; i++) begin
        exp_data = (base_addr[b] + 32'(4 * (i % LOAD_WORDS[b]))) ^ PATTERN;
        n_checks++;
        if (empty[b] !== 1'b0) begin
          $display("Error: %s buffer %0d ran empty after %0d of %0d words",
                   r.name, b, i, r.pops[b]);
          n_errors++;
        end
        else if (rd_data[b] !== exp_data) begin
          $display("Error: %s buffer %0d word %0d expected %h actual %h",
                   r.name, b, i, exp_data, rd_data[b]);
          n_errors++;
        end
        rd_en[b] = 1'b1;
        next_edge();
        rd_en[b] = 1'b0;
      end
    end
    n_checks += 3;
    if (empty !== r.empty_exp) begin
      $display("Error: %s empty expected %b actual %b", r.name, r.empty_exp, empty);
      n_errors++;
    end
    if (pe_status !== r.status) begin
      $display("Error: %s status expected %h actual %h", r.name, r.status, pe_status);
      n_errors++;
    end
    if (wb_o.cyc !== 1'b0) begin
      $display("%s left a bus cycle open after the loader went idle", r.name);
      n_errors++;
    end
  endtask

  initial begin : stimulus
    mem_ctrl = '0;
    rd_en = '0;
    wb_i = '0;
    base_addr[0] = 32'h0000_1000;
    base_addr[1] = 32'h0000_2000;
    base_addr[2] = 32'h0000_4000;
    lfsr_state = 16'd58011;
    err_en = 1'b0;
    err_addr = '0;
    n_checks = 0;
    n_errors = 0;
    load_table();
    @(posedge resetn_all);
    for (int t = 0; t < NUM_ROWS; t++) begin
      run_row(rows[t]);
    end
    $display("checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTS PASSED");
    end
    else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // rows times the slowest row
  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog expired before the tests finished");
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: wb_pkg.sv
// ====================
// wishbone classic read-master types and bus constants
// shared by the read sequencer and the top level ports
// ====================
package wb_pkg;

  // byte address width of the external bus
  localparam int unsigned ADDR_W = 32;

  // one bus word, also the address step between words
  localparam int unsigned BYTES_PER_WORD = 4;

  typedef logic [ADDR_W-1:0] wb_addr_t;
  typedef logic [BYTES_PER_WORD*8-1:0] wb_data_t;

  // master to slave, 35 bits
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
  } wb_req_t;

  // slave to master, 34 bits
  typedef struct packed {
    logic     ack;
    logic     err;
    wb_data_t dat;
  } wb_rsp_t;

endpackage
